// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

    // Width of the R-type shift amount field.
    parameter int SHAMT_W = 5;

    // Decoded operations handled by the execute stage.
    typedef enum logic [5:0] {
        NOP,
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA,
        LUI,
        CLO, CLZ,
        MOVZ, MOVN,
        BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ,
        JAL,
        MULT, MULTU,
        MADD, MADDU, MSUB, MSUBU
    } op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI
    } alu_func_t;

    // Condition tested by the branch judge.
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LEZ,
        BR_GTZ,
        BR_LTZ,
        BR_GEZ
    } branch_t;

endpackage

// File: source/exec_types_pkg.sv
package exec_types_pkg;

    typedef logic [31:0] word_t;

    // Destination register number.
    typedef logic [4:0] reg_addr_t;

    // Iterative multiplier sequence.
    typedef enum logic [1:0] {
        M_IDLE,
        M_RUN,
        M_ACC,
        M_DONE
    } mul_state_t;

endpackage

// File: source/alu.sv
`timescale 1ns/1ns

module alu (
    input  exec_types_pkg::word_t            a,
    input  exec_types_pkg::word_t            b,
    input  mips_isa_pkg::alu_func_t          func,
    input  logic [mips_isa_pkg::SHAMT_W-1:0] shamt,
    output exec_types_pkg::word_t            y,
    output logic                             overflow
);
    import mips_isa_pkg::*;
    import exec_types_pkg::*;

    word_t sum;
    word_t diff;
    logic  sum_of;
    logic  diff_of;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed wrap shows as a sign flip against the operand signs.
    assign sum_of  = (a[31] == b[31]) && (sum[31] != a[31]);
    assign diff_of = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb
    begin
        y        = sum;
        overflow = 1'b0;
        case (func)
            ALU_ADD:
            begin
                y        = sum;
                overflow = sum_of;
            end
            ALU_ADDU: y = sum;
            ALU_SUB:
            begin
                y        = diff;
                overflow = diff_of;
            end
            ALU_SUBU: y = diff;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: y = {31'b0, a < b};
            // Shifts act on rt, the amount comes from sa or rs.
            ALU_SLL:  y = b << shamt;
            ALU_SRL:  y = b >> shamt;
            ALU_SRA:  y = $signed(b) >>> shamt;
            ALU_LUI:  y = {b[15:0], 16'b0};
            default:  y = sum;
        endcase
    end

endmodule

// File: source/count_lead.sv
`timescale 1ns/1ns

module count_lead (
    input  exec_types_pkg::word_t a,
    output logic [5:0]            count
);
    import exec_types_pkg::*;

    word_t x16;
    word_t x8;
    word_t x4;
    word_t x2;
    logic  n16, n8, n4, n2, n1;

    // Binary search on the leading edge, halving the window each stage.
    assign n16 = ~|a[31:16];
    assign x16 = n16 ? {a[15:0], 16'b0} : a;
    assign n8  = ~|x16[31:24];
    assign x8  = n8 ? {x16[23:0], 8'b0} : x16;
    assign n4  = ~|x8[31:28];
    assign x4  = n4 ? {x8[27:0], 4'b0} : x8;
    assign n2  = ~|x4[31:30];
    assign x2  = n2 ? {x4[29:0], 2'b0} : x4;
    assign n1  = ~x2[31];

    // An all-zero word reports 32.
    assign count = (a == '0) ? 6'd32 : {1'b0, n16, n8, n4, n2, n1};

endmodule

// File: source/branch_judge.sv
`timescale 1ns/1ns

module branch_judge (
    input  exec_types_pkg::word_t a,
    input  exec_types_pkg::word_t b,
    input  mips_isa_pkg::branch_t branch,
    output logic                  taken
);
    import mips_isa_pkg::*;

    logic eq;
    logic a_neg;
    logic a_zero;

    assign eq     = (a == b);
    assign a_neg  = a[31];
    assign a_zero = (a == '0);

    always_comb
    begin
        case (branch)
            BR_EQ:   taken = eq;
            BR_NE:   taken = ~eq;
            BR_LEZ:  taken = a_neg | a_zero;
            BR_GTZ:  taken = ~a_neg & ~a_zero;
            BR_LTZ:  taken = a_neg;
            BR_GEZ:  taken = ~a_neg;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: source/mul_unit.sv
`timescale 1ns/1ns

module mul_unit #(
    parameter int MUL_STEPS = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  mips_isa_pkg::op_t     op,
    input  exec_types_pkg::word_t a,
    input  exec_types_pkg::word_t b,
    output logic                  idle,
    output logic                  done,
    output exec_types_pkg::word_t hi,
    output exec_types_pkg::word_t lo
);
    import mips_isa_pkg::*;
    import exec_types_pkg::*;

    localparam int ITERS = 32 / MUL_STEPS;
    localparam int CNT_W = $clog2(ITERS);

    mul_state_t       state;
    logic [CNT_W-1:0] cnt;
    logic             acc;
    logic             sub;
    logic             neg;
    logic             op_signed;
    logic             last;
    word_t            mag_a;
    word_t            mag_b;
    word_t            mplier;
    logic [63:0]      mcand;
    logic [63:0]      prod;
    logic [63:0]      prod_next;
    logic [63:0]      prod_fix;

    assign op_signed = op inside {MULT, MADD, MSUB};
    assign mag_a     = (op_signed && a[31]) ? -a : a;
    assign mag_b     = (op_signed && b[31]) ? -b : b;
    assign last      = (state == M_RUN) && (cnt == CNT_W'(ITERS - 1));
    assign idle      = (state == M_IDLE);
    assign done      = (state == M_DONE);

    // Retire MUL_STEPS multiplier bits per cycle.
    always_comb
    begin
        prod_next = prod;
        for (int k = 0; k < MUL_STEPS; k++)
        begin
            if (mplier[k])
            begin
                prod_next = prod_next + (mcand << k);
            end
        end
    end

    assign prod_fix = neg ? -prod_next : prod_next;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= M_IDLE;
            cnt   <= '0;
            acc   <= 1'b0;
            sub   <= 1'b0;
            hi    <= '0;
            lo    <= '0;
        end
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (start)
                    begin
                        state <= M_RUN;
                        cnt   <= '0;
                        acc   <= op inside {MADD, MADDU, MSUB, MSUBU};
                        sub   <= op inside {MSUB, MSUBU};
                    end
                end
                M_RUN:
                begin
                    cnt <= cnt + 1'b1;
                    if (last && acc)
                        state <= M_ACC;
                    else if (last)
                    begin
                        // HI/LO are already new while done is high.
                        state    <= M_DONE;
                        {hi, lo} <= prod_fix;
                    end
                end
                M_ACC:
                begin
                    state    <= M_DONE;
                    {hi, lo} <= sub ? ({hi, lo} - prod) : ({hi, lo} + prod);
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (idle && start)
        begin
            mcand  <= {32'b0, mag_a};
            mplier <= mag_b;
            prod   <= '0;
            neg    <= op_signed && (a[31] ^ b[31]);
        end
        else if (state == M_RUN)
        begin
            mcand  <= mcand << MUL_STEPS;
            mplier <= mplier >> MUL_STEPS;
            prod   <= last ? prod_fix : prod_next;
        end
    end

    // The issuing stage must wait for an idle unit.
    assert property (@(posedge clk) disable iff (!rst_n) start |-> idle)
        else $error("mul_unit: start while busy");

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("mul_unit: done high for two cycles");

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  mips_isa_pkg::op_t                op,
    input  exec_types_pkg::word_t            srca, srcb, imm,
    input  logic [mips_isa_pkg::SHAMT_W-1:0] shamt,
    input  logic                             use_imm, use_shamt,
    input  mips_isa_pkg::branch_t            branch,
    input  logic                             is_link, regwrite_in,
    input  exec_types_pkg::reg_addr_t        dest,
    input  exec_types_pkg::word_t            pcplus4,
    output logic                             out_valid,
    input  logic                             out_ready,
    output exec_types_pkg::word_t            result,
    output logic                             taken, regwrite, exception_of,
    output exec_types_pkg::reg_addr_t        dest_out,
    output logic                             mul_start,
    output mips_isa_pkg::op_t                mul_op,
    output exec_types_pkg::word_t            mul_a, mul_b,
    input  logic                             mul_idle, mul_done,
    input  exec_types_pkg::word_t            mul_lo
);
    import mips_isa_pkg::*;
    import exec_types_pkg::*;

    word_t      op_a, op_b, alu_y, cl_in, pcplus8, res_d;
    alu_func_t  func;
    logic [5:0] cl_count;
    logic       alu_of, br_taken, wr_d, of_d;
    logic       is_mul, is_cl, is_mov, accept;
    logic       mul_pend, mul_wait;

    assign op_a = use_shamt ? {{(32 - SHAMT_W){1'b0}}, shamt} : srca;
    assign op_b = use_imm ? imm : srcb;

    assign is_mul = op inside {MULT, MULTU, MADD, MADDU, MSUB, MSUBU};
    assign is_cl  = op inside {CLO, CLZ};
    assign is_mov = op inside {MOVZ, MOVN};

    always_comb
    begin
        case (op)
            ADD:     func = ALU_ADD;
            SUB:     func = ALU_SUB;
            SUBU:    func = ALU_SUBU;
            AND:     func = ALU_AND;
            OR:      func = ALU_OR;
            XOR:     func = ALU_XOR;
            NOR:     func = ALU_NOR;
            SLT:     func = ALU_SLT;
            SLTU:    func = ALU_SLTU;
            SLL:     func = ALU_SLL;
            SRL:     func = ALU_SRL;
            SRA:     func = ALU_SRA;
            LUI:     func = ALU_LUI;
            default: func = ALU_ADDU;
        endcase
    end

    // CLO counts leading zeros of the inverted word.
    assign cl_in = (op == CLZ) ? op_a : ~op_a;

    alu u_alu (.a(op_a), .b(op_b), .func(func), .shamt(op_a[SHAMT_W-1:0]),
               .y(alu_y), .overflow(alu_of));
    count_lead u_count_lead (.a(cl_in), .count(cl_count));
    branch_judge u_branch_judge (.a(op_a), .b(op_b), .branch(branch), .taken(br_taken));

    assign pcplus8 = pcplus4 + 32'd4;
    assign res_d   = is_link ? pcplus8 :
                     is_cl   ? {26'b0, cl_count} :
                     is_mov  ? op_a : alu_y;
    assign wr_d    = (op == MOVZ) ? (op_b == '0) :
                     (op == MOVN) ? (op_b != '0) : regwrite_in;
    assign of_d    = (is_cl || is_mul) ? 1'b0 : alu_of;

    // One result slot, and no new work while a multiply is outstanding.
    assign in_ready  = (!out_valid || out_ready) && !mul_pend;
    assign accept    = in_valid && in_ready;
    assign mul_start = mul_wait && mul_idle;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            mul_pend  <= 1'b0;
            mul_wait  <= 1'b0;
        end
        else
        begin
            if (accept && is_mul)
            begin
                mul_pend <= 1'b1;
                mul_wait <= 1'b1;
            end
            else
            begin
                if (mul_start)
                    mul_wait <= 1'b0;
                if (mul_done)
                    mul_pend <= 1'b0;
            end
            if ((accept && !is_mul) || mul_done)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            dest_out <= dest;
        if (accept && is_mul)
        begin
            mul_op <= op;
            mul_a  <= op_a;
            mul_b  <= op_b;
        end
        if (accept && !is_mul)
        begin
            result       <= res_d;
            taken        <= br_taken;
            regwrite     <= wr_d;
            exception_of <= of_d;
        end
        else if (mul_done)
        begin
            result       <= mul_lo;
            taken        <= 1'b0;
            regwrite     <= 1'b0;
            exception_of <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable({result, taken, regwrite, exception_of, dest_out}))
        else $error("exec_unit: output changed under back-pressure");

    // The input side stays closed while the multiplier is busy.
    assert property (@(posedge clk) disable iff (!rst_n)
        !mul_idle |-> !in_ready)
        else $error("exec_unit: in_ready high with a multiply pending");

endmodule

// File: source/exec_top.sv
`timescale 1ns/1ns

module exec_top #(
    parameter int MUL_STEPS = 2
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  mips_isa_pkg::op_t                op,
    input  exec_types_pkg::word_t            srca, srcb, imm,
    input  logic [mips_isa_pkg::SHAMT_W-1:0] shamt,
    input  logic                             use_imm, use_shamt,
    input  mips_isa_pkg::branch_t            branch,
    input  logic                             is_link, regwrite_in,
    input  exec_types_pkg::reg_addr_t        dest,
    input  exec_types_pkg::word_t            pcplus4,
    output logic                             out_valid,
    input  logic                             out_ready,
    output exec_types_pkg::word_t            result,
    output logic                             taken, regwrite, exception_of,
    output exec_types_pkg::reg_addr_t        dest_out,
    output exec_types_pkg::word_t            hi, lo
);
    import mips_isa_pkg::*;
    import exec_types_pkg::*;

    logic  mul_start;
    logic  mul_idle;
    logic  mul_done;
    op_t   mul_op;
    word_t mul_a;
    word_t mul_b;

    exec_unit u_exec_unit (
        .mul_lo (lo),
        .*
    );

    mul_unit #(
        .MUL_STEPS (MUL_STEPS)
    ) u_mul_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .op    (mul_op),
        .a     (mul_a),
        .b     (mul_b),
        .idle  (mul_idle),
        .done  (mul_done),
        .hi    (hi),
        .lo    (lo)
    );

endmodule

// File: testbench/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Architectural HI/LO, updated in program order as results retire.
word_t model_hi = '0;
word_t model_lo = '0;

function automatic int lead_count(input word_t w, input logic bitval);
    int   n;
    logic run;
    n   = 0;
    run = 1'b1;
    for (int i = 31; i >= 0; i--)
    begin
        if (run && (w[i] == bitval))
            n++;
        else
            run = 1'b0;
    end
    return n;
endfunction

function automatic word_t exec_ref(
    input  op_t        opc,
    input  word_t      ra,
    input  word_t      rb,
    input  word_t      rimm,
    input  logic [4:0] rsh,
    input  logic       rui,
    input  logic       rus,
    input  branch_t    rbr,
    input  logic       rlink,
    input  logic       rwr,
    input  word_t      rpc,
    output logic       exp_taken,
    output logic       exp_wr,
    output logic       exp_of
);
    word_t       x;
    word_t       y;
    word_t       r;
    longint      wide;
    logic [63:0] prod;
    x      = rus ? {27'b0, rsh} : ra;
    y      = rui ? rimm : rb;
    exp_wr = rwr;
    exp_of = 1'b0;
    case (rbr)
        BR_EQ:   exp_taken = (x == y);
        BR_NE:   exp_taken = (x != y);
        BR_LEZ:  exp_taken = ($signed(x) <= 0);
        BR_GTZ:  exp_taken = ($signed(x) > 0);
        BR_LTZ:  exp_taken = ($signed(x) < 0);
        BR_GEZ:  exp_taken = ($signed(x) >= 0);
        default: exp_taken = 1'b0;
    endcase
    case (opc)
        ADD, SUB:
        begin
            if (opc == ADD)
                wide = longint'($signed(x)) + longint'($signed(y));
            else
                wide = longint'($signed(x)) - longint'($signed(y));
            r = wide[31:0];
            // Wrapped when the exact value no longer fits in 32 signed bits.
            exp_of = (wide != longint'($signed(r)));
        end
        SUBU: r = x - y;
        AND:  r = x & y;
        OR:   r = x | y;
        XOR:  r = x ^ y;
        NOR:  r = ~(x | y);
        SLT:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        SLTU: r = (x < y) ? 32'd1 : 32'd0;
        SLL:  r = y << x[4:0];
        SRL:  r = y >> x[4:0];
        SRA:  r = $signed(y) >>> x[4:0];
        LUI:  r = {y[15:0], 16'h0000};
        CLZ:  r = word_t'(lead_count(x, 1'b0));
        CLO:  r = word_t'(lead_count(x, 1'b1));
        MOVZ, MOVN:
        begin
            r      = x;
            exp_wr = (opc == MOVZ) ? (y == '0) : (y != '0);
        end
        MULT, MULTU, MADD, MADDU, MSUB, MSUBU:
        begin
            if (opc inside {MULTU, MADDU, MSUBU})
                prod = {32'b0, x} * {32'b0, y};
            else
                prod = longint'($signed(x)) * longint'($signed(y));
            if (opc inside {MADD, MADDU})
                {model_hi, model_lo} = {model_hi, model_lo} + prod;
            else if (opc inside {MSUB, MSUBU})
                {model_hi, model_lo} = {model_hi, model_lo} - prod;
            else
                {model_hi, model_lo} = prod;
            r         = model_lo;
            exp_wr    = 1'b0;
            exp_taken = 1'b0;
        end
        default: r = x + y;
    endcase
    if (rlink)
        r = rpc + 32'd4;
    return r;
endfunction

`endif

// File: testbench/exec_tb.sv
`timescale 1ns/1ns

module exec_tb;
    import mips_isa_pkg::*;
    import exec_types_pkg::*;

    `include "exec_ref.svh"

    localparam int N_ALU   = 200;
    localparam int N_CL    = 40;
    localparam int N_CTL   = 60;
    localparam int N_MUL   = 40;
    localparam int N_MIX   = 150;
    localparam int N_TOTAL = N_ALU + N_CL + N_CTL + N_MUL + N_MIX;
    // Two bits per cycle, plus start, accumulate, done and output register.
    localparam int MUL_LAT = 32 / 2 + 4;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid, in_ready, out_valid, out_ready;
    op_t        op;
    word_t      srca, srcb, imm, pcplus4, result, hi, lo;
    logic [4:0] shamt;
    logic       use_imm, use_shamt, is_link, regwrite_in;
    branch_t    branch;
    reg_addr_t  dest, dest_out;
    logic       taken, regwrite, exception_of;

    op_t     alu_ops[14] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
                             SLT, SLTU, SLL, SRL, SRA, LUI};
    op_t     mul_ops[6]  = '{MULT, MULTU, MADD, MADDU, MSUB, MSUBU};
    op_t     br_ops[6]   = '{BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ};
    branch_t br_types[6] = '{BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ};

    // Every accepted instruction, in issue order.
    op_t        s_op[$];
    word_t      s_a[$], s_b[$], s_imm[$], s_pc[$];
    logic [4:0] s_sh[$];
    logic       s_ui[$], s_us[$], s_link[$], s_wr[$];
    branch_t    s_br[$];
    reg_addr_t  s_dest[$];
    int         s_cyc[$];

    int   cycle = 0;
    int   limit = 0;
    int   errors = 0;
    int   checks = 0;
    int   n_checked = 0;
    int   n_tests = 0;
    int   err_mark = 0;
    int   chk_mark = 0;
    int   ins_mark = 0;
    logic bp_mode = 1'b0;
    logic mul_out = 1'b0;

    exec_top dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle > limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    always @(negedge clk)
    begin
        if (bp_mode)
            out_ready = 1'($urandom);
        else
            out_ready = 1'b1;
    end

    function automatic logic is_mul_op(input op_t o);
        return o inside {MULT, MULTU, MADD, MADDU, MSUB, MSUBU};
    endfunction

    function automatic word_t rand_word();
        case ($urandom_range(0, 7))
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0000;
            default: return $urandom;
        endcase
    endfunction

    task automatic check_field(input int idx, input string what, input word_t got,
                               input word_t exp_v);
        checks++;
        assert (got === exp_v)
        else
        begin
            $display("mismatch at %0t ns: instr %0d %s %s got %h expected %h",
                     $time, idx, s_op[idx].name(), what, got, exp_v);
            errors++;
        end
    endtask

    always @(posedge clk)
    begin
        word_t exp_res;
        logic  exp_taken;
        logic  exp_wr;
        logic  exp_of;
        int    i;
        if (rst_n)
        begin
            if (out_valid)
                mul_out = 1'b0;
            assert (!(mul_out && in_ready))
            else
            begin
                $display("error at %0t ns: in_ready was high with a multiply outstanding",
                         $time);
                errors++;
            end
            if (in_valid && in_ready && is_mul_op(op))
                mul_out = 1'b1;
            if (out_valid && out_ready)
            begin
                i = n_checked;
                assert (i < s_op.size())
                else
                begin
                    $display("error at %0t ns: a result came out with no instruction issued",
                             $time);
                    errors++;
                end
                if (i < s_op.size())
                begin
                    exp_res = exec_ref(s_op[i], s_a[i], s_b[i], s_imm[i], s_sh[i], s_ui[i],
                                       s_us[i], s_br[i], s_link[i], s_wr[i], s_pc[i],
                                       exp_taken, exp_wr, exp_of);
                    check_field(i, "result", result, exp_res);
                    check_field(i, "taken", 32'(taken), 32'(exp_taken));
                    check_field(i, "regwrite", 32'(regwrite), 32'(exp_wr));
                    check_field(i, "overflow", 32'(exception_of), 32'(exp_of));
                    check_field(i, "dest", 32'(dest_out), 32'(s_dest[i]));
                    check_field(i, "hi", hi, model_hi);
                    check_field(i, "lo", lo, model_lo);
                    if (!bp_mode && !is_mul_op(s_op[i]))
                        check_field(i, "latency", 32'(cycle - s_cyc[i]), 32'd1);
                    n_checked++;
                end
            end
        end
    end

    // Drives one instruction and returns at the edge that accepts it.
    task automatic issue(input op_t o, input word_t a, input word_t b, input word_t im,
                         input logic [4:0] sh, input logic ui, input logic us,
                         input branch_t br, input logic lk, input logic wr);
        @(negedge clk);
        op          = o;
        srca        = a;
        srcb        = b;
        imm         = im;
        shamt       = sh;
        use_imm     = ui;
        use_shamt   = us;
        branch      = br;
        is_link     = lk;
        regwrite_in = wr;
        dest        = 5'($urandom);
        pcplus4     = word_t'($urandom) & 32'hffff_fffc;
        in_valid    = 1'b1;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
        s_op.push_back(o);
        s_a.push_back(a);
        s_b.push_back(b);
        s_imm.push_back(im);
        s_sh.push_back(sh);
        s_ui.push_back(ui);
        s_us.push_back(us);
        s_br.push_back(br);
        s_link.push_back(lk);
        s_wr.push_back(wr);
        s_dest.push_back(dest);
        s_pc.push_back(pcplus4);
        s_cyc.push_back(cycle);
    endtask

    task automatic gen_alu();
        op_t         o;
        logic [15:0] h;
        word_t       im;
        logic        ui;
        logic        us;
        o  = alu_ops[$urandom_range(0, 13)];
        h  = 16'($urandom);
        // Logical immediates are zero-extended, the rest sign-extended.
        im = (o inside {AND, OR, XOR, LUI}) ? {16'b0, h} : {{16{h[15]}}, h};
        ui = (o == LUI) ? 1'b1 : (o inside {SLL, SRL, SRA}) ? 1'b0 : 1'($urandom);
        us = (o inside {SLL, SRL, SRA}) ? 1'($urandom) : 1'b0;
        issue(o, rand_word(), rand_word(), im, 5'($urandom), ui, us, BR_NONE, 1'b0, 1'b1);
    endtask

    task automatic gen_cl(input op_t o, input word_t w);
        issue(o, w, rand_word(), 32'd0, 5'd0, 1'b0, 1'b0, BR_NONE, 1'b0, 1'b1);
    endtask

    task automatic gen_cl_rand();
        op_t   o;
        word_t w;
        o = 1'($urandom) ? CLO : CLZ;
        w = word_t'($urandom) >> $urandom_range(0, 32);
        gen_cl(o, (o == CLO) ? ~w : w);
    endtask

    task automatic gen_ctl();
        int    k;
        word_t a;
        word_t b;
        k = $urandom_range(0, 8);
        case ($urandom_range(0, 3))
            0:       a = 32'd0;
            1:       a = 32'h8000_0000 | $urandom;
            2:       a = 32'h7fff_ffff & $urandom;
            default: a = rand_word();
        endcase
        b = 1'($urandom) ? a : rand_word();
        if (k < 6)
            issue(br_ops[k], a, b, 32'd0, 5'd0, 1'b0, 1'b0, br_types[k], 1'b0, 1'b0);
        else if (k == 6)
            issue(JAL, a, b, 32'd0, 5'd0, 1'b0, 1'b0, BR_NONE, 1'b1, 1'b1);
        else
            issue((k == 7) ? MOVZ : MOVN, a, 1'($urandom) ? 32'd0 : rand_word(), 32'd0,
                  5'd0, 1'b0, 1'b0, BR_NONE, 1'b0, 1'b1);
    endtask

    task automatic gen_mul(input op_t o);
        issue(o, rand_word(), rand_word(), 32'd0, 5'd0, 1'b0, 1'b0, BR_NONE, 1'b0, 1'b0);
    endtask

    // Lets the pipe drain, then reports the test just run.
    task automatic finish_test(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        while (n_checked != s_op.size())
            @(negedge clk);
        n_tests++;
        $display("test %0d %s: %0d instructions, %0d checks, %0d errors", n_tests, name,
                 n_checked - ins_mark, checks - chk_mark, errors - err_mark);
        ins_mark = n_checked;
        chk_mark = checks;
        err_mark = errors;
    endtask

    initial
    begin
        void'($urandom(32773));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        op          = NOP;
        srca        = '0;
        srcb        = '0;
        imm         = '0;
        shamt       = '0;
        use_imm     = 1'b0;
        use_shamt   = 1'b0;
        branch      = BR_NONE;
        is_link     = 1'b0;
        regwrite_in = 1'b0;
        dest        = '0;
        pcplus4     = '0;
        limit       = 2 * N_TOTAL * (MUL_LAT + 2) + 8;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (N_ALU) gen_alu();
        finish_test("alu ops");

        gen_cl(CLZ, 32'd0);
        gen_cl(CLO, 32'd0);
        gen_cl(CLZ, 32'hffff_ffff);
        gen_cl(CLO, 32'hffff_ffff);
        gen_cl(CLZ, 32'd1);
        gen_cl(CLO, 32'd1);
        repeat (N_CL - 6) gen_cl_rand();
        finish_test("clz and clo");

        repeat (N_CTL) gen_ctl();
        finish_test("branch, link and move");

        repeat (N_MUL / 2)
        begin
            gen_mul(1'($urandom) ? MULT : MULTU);
            gen_mul(mul_ops[$urandom_range(2, 5)]);
        end
        finish_test("multiply and accumulate");

        bp_mode = 1'b1;
        repeat (N_MIX)
        begin
            case ($urandom_range(0, 3))
                0:       gen_alu();
                1:       gen_cl_rand();
                2:       gen_ctl();
                default: gen_mul(mul_ops[$urandom_range(0, 5)]);
            endcase
        end
        finish_test("mixed with back-pressure");

        $display("summary: %0d tests, %0d instructions, %0d checks, %0d errors",
                 n_tests, n_checked, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+testbench
source/mips_isa_pkg.sv
source/exec_types_pkg.sv
source/alu.sv
source/count_lead.sv
source/branch_judge.sv
source/mul_unit.sv
source/exec_unit.sv
source/exec_top.sv
testbench/exec_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exec_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
